// File: common/rvPkg.sv
//==============================
// RV32I core shared definitions
//   word and field widths
//   major opcodes, ALU operations
//   write-back and forwarding selects
//==============================
`default_nettype none

package rvPkg;

    localparam int xlen     = 32;  // Data and address width
    localparam int instW    = 32;
    localparam int regAddrW = 5;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB   // LUI, immediate straight through
    } aluOpE;

    typedef enum logic {
        wbAlu,
        wbMem
    } wbSelE;

    // Operand source in EX
    typedef enum logic [1:0] {
        fwdNone,
        fwdExMem,
        fwdMemWb
    } fwdSelE;

endpackage

`default_nettype wire

// File: pipeline/pipeRegs.sv
//==============================
// Pipeline stage registers
//   ifIdReg   fetch to decode
//   idExReg   decode to execute
//   exMemReg  execute to memory
//   memWbReg  memory to write-back
//==============================
`timescale 1ns/1ps
`default_nettype none

module ifIdReg (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    stall,
    input  logic                    flush,
    input  logic [rvPkg::xlen-1:0]  pcIn,
    input  logic [rvPkg::instW-1:0] instIn,
    output logic [rvPkg::xlen-1:0]  pcOut,
    output logic [rvPkg::instW-1:0] instOut,
    output logic                    validOut
);
    // An empty slot holds an all-zero word, which decodes as a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
            instOut  <= '0;
        end else if (flush) begin
            validOut <= 1'b0;
            instOut  <= '0;
        end else if (!stall) begin
            validOut <= 1'b1;
            instOut  <= instIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall)
            pcOut <= pcIn;
    end

    holdOnStall: assert property (@(posedge clk) disable iff (!arstN)
        stall && !flush |=> $stable(instOut) && $stable(pcOut) && $stable(validOut));

endmodule

module idExReg (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       bubble,
    input  logic                       flush,
    input  logic                       regWriteIn, memReadIn, memWriteIn, aluSrcIn, isBranchIn,
    input  rvPkg::aluOpE               aluOpIn,
    input  rvPkg::wbSelE               wbSelIn,
    input  logic [rvPkg::regAddrW-1:0] rs1In, rs2In, rdIn,
    input  logic [rvPkg::xlen-1:0]     rData1In, rData2In, immIn, pcIn,
    output logic                       regWriteOut, memReadOut, memWriteOut, aluSrcOut,
    output logic                       isBranchOut,
    output rvPkg::aluOpE               aluOpOut,
    output rvPkg::wbSelE               wbSelOut,
    output logic [rvPkg::regAddrW-1:0] rs1Out, rs2Out, rdOut,
    output logic [rvPkg::xlen-1:0]     rData1Out, rData2Out, immOut, pcOut
);
    // Control only; a cleared slot is a no-op
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteOut, memReadOut, memWriteOut, aluSrcOut, isBranchOut} <= '0;
            aluOpOut <= rvPkg::aluAdd;
            wbSelOut <= rvPkg::wbAlu;
        end else if (bubble || flush) begin
            {regWriteOut, memReadOut, memWriteOut, aluSrcOut, isBranchOut} <= '0;
            aluOpOut <= rvPkg::aluAdd;
            wbSelOut <= rvPkg::wbAlu;
        end else begin
            {regWriteOut, memReadOut, memWriteOut, aluSrcOut, isBranchOut} <=
                {regWriteIn, memReadIn, memWriteIn, aluSrcIn, isBranchIn};
            aluOpOut <= aluOpIn;
            wbSelOut <= wbSelIn;
        end
    end

    always_ff @(posedge clk) begin
        rs1Out    <= rs1In;
        rs2Out    <= rs2In;
        rdOut     <= rdIn;
        rData1Out <= rData1In;
        rData2Out <= rData2In;
        immOut    <= immIn;
        pcOut     <= pcIn;
    end

endmodule

module exMemReg (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       regWriteIn, memReadIn, memWriteIn,
    input  rvPkg::wbSelE               wbSelIn,
    input  logic [rvPkg::regAddrW-1:0] rdIn,
    input  logic [rvPkg::xlen-1:0]     aluResultIn, storeDataIn,
    output logic                       regWriteOut, memReadOut, memWriteOut,
    output rvPkg::wbSelE               wbSelOut,
    output logic [rvPkg::regAddrW-1:0] rdOut,
    output logic [rvPkg::xlen-1:0]     aluResultOut, storeDataOut
);
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteOut, memReadOut, memWriteOut} <= '0;
            wbSelOut <= rvPkg::wbAlu;
        end else begin
            {regWriteOut, memReadOut, memWriteOut} <= {regWriteIn, memReadIn, memWriteIn};
            wbSelOut <= wbSelIn;
        end
    end

    always_ff @(posedge clk) begin
        rdOut        <= rdIn;
        aluResultOut <= aluResultIn;  // Memory address for LW and SW
        storeDataOut <= storeDataIn;
    end

endmodule

module memWbReg (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       regWriteIn,
    input  rvPkg::wbSelE               wbSelIn,
    input  logic [rvPkg::regAddrW-1:0] rdIn,
    input  logic [rvPkg::xlen-1:0]     aluResultIn, memDataIn,
    output logic                       regWriteOut,
    output rvPkg::wbSelE               wbSelOut,
    output logic [rvPkg::regAddrW-1:0] rdOut,
    output logic [rvPkg::xlen-1:0]     aluResultOut, memDataOut
);
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteOut <= 1'b0;
            wbSelOut    <= rvPkg::wbAlu;
        end else begin
            regWriteOut <= regWriteIn;
            wbSelOut    <= wbSelIn;
        end
    end

    always_ff @(posedge clk) begin
        rdOut        <= rdIn;
        aluResultOut <= aluResultIn;
        memDataOut   <= memDataIn;
    end

    // x0 writes are dropped at decode and must never reach retirement
    noX0Write: assert property (@(posedge clk) disable iff (!arstN)
        regWriteOut |-> rdOut != '0);

endmodule

`default_nettype wire

// File: hdl/decoder.sv
//==============================
// Instruction decoder
//   field split, I/S/B/U immediates
//   control for the RV32I subset
//==============================
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [rvPkg::instW-1:0]    inst,
    output logic [rvPkg::regAddrW-1:0] rs1,
    output logic [rvPkg::regAddrW-1:0] rs2,
    output logic [rvPkg::regAddrW-1:0] rd,
    output logic                       regWrite,
    output logic                       memRead,
    output logic                       memWrite,
    output logic                       aluSrc,
    output rvPkg::aluOpE               aluOp,
    output rvPkg::wbSelE               wbSel,
    output logic                       isBranch,
    output logic [rvPkg::xlen-1:0]     imm
);
    rvPkg::opcodeE opcode;
    logic [2:0]    funct3;
    logic          writesRd;

    assign opcode   = rvPkg::opcodeE'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign rd       = inst[11:7];
    assign regWrite = writesRd && (rd != '0);  // Writes to x0 vanish here

    always_comb begin
        case (opcode)
            rvPkg::opOpImm,
            rvPkg::opLoad:   imm = {{20{inst[31]}}, inst[31:20]};
            rvPkg::opStore:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rvPkg::opBranch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rvPkg::opLui:    imm = {inst[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    // Anything unsupported leaves all control low
    always_comb begin
        writesRd = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        aluOp    = rvPkg::aluAdd;
        wbSel    = rvPkg::wbAlu;
        isBranch = 1'b0;
        case (opcode)
            rvPkg::opOp: begin
                writesRd = 1'b1;
                case (funct3)
                    3'b000:  aluOp = inst[30] ? rvPkg::aluSub : rvPkg::aluAdd;
                    3'b010:  aluOp = rvPkg::aluSlt;
                    3'b100:  aluOp = rvPkg::aluXor;
                    3'b110:  aluOp = rvPkg::aluOr;
                    3'b111:  aluOp = rvPkg::aluAnd;
                    default: writesRd = 1'b0;  // Shifts, SLTU
                endcase
            end
            rvPkg::opOpImm: begin
                writesRd = (funct3 == 3'b000);  // ADDI only
                aluSrc   = 1'b1;
            end
            rvPkg::opLoad: begin
                writesRd = (funct3 == 3'b010);  // Word loads only
                memRead  = (funct3 == 3'b010);
                aluSrc   = 1'b1;
                wbSel    = rvPkg::wbMem;
            end
            rvPkg::opStore: begin
                memWrite = (funct3 == 3'b010);
                aluSrc   = 1'b1;
            end
            rvPkg::opLui: begin
                writesRd = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = rvPkg::aluPassB;
            end
            rvPkg::opBranch: begin
                isBranch = (funct3 == 3'b000);  // BEQ
                aluOp    = rvPkg::aluSub;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
//==============================
// Register file, 31 x 32
//   two read ports, one write port
//   write-through, x0 reads zero
//==============================
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic                       we,
    input  logic [rvPkg::regAddrW-1:0] wAddr,
    input  logic [rvPkg::xlen-1:0]     wData,
    output logic [rvPkg::xlen-1:0]     rData1,
    output logic [rvPkg::xlen-1:0]     rData2
);
    logic [rvPkg::xlen-1:0] regs [1:31];  // No storage for x0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // WB write seen by ID in the same cycle
    assign rData1 = (rs1 == '0) ? '0 : (we && wAddr == rs1) ? wData : regs[rs1];
    assign rData2 = (rs2 == '0) ? '0 : (we && wAddr == rs2) ? wData : regs[rs2];

    x0ReadsZero: assert property (@(posedge clk)
        (rs1 == '0 |-> rData1 == '0) and (rs2 == '0 |-> rData2 == '0));

endmodule

`default_nettype wire

// File: hdl/alu.sv
//==============================
// Execute stage ALU
//   operand forwarding muxes
//   result and BEQ resolution
//==============================
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rvPkg::aluOpE           aluOp,
    input  logic                   aluSrc,
    input  logic                   isBranch,
    input  rvPkg::fwdSelE          fwdA,
    input  rvPkg::fwdSelE          fwdB,
    input  logic [rvPkg::xlen-1:0] rData1,
    input  logic [rvPkg::xlen-1:0] rData2,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] pc,
    input  logic [rvPkg::xlen-1:0] exMemResult,
    input  logic [rvPkg::xlen-1:0] memWbResult,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic [rvPkg::xlen-1:0] storeData,
    output logic                   branchTaken,
    output logic [rvPkg::xlen-1:0] branchTarget
);
    logic [rvPkg::xlen-1:0] opA;
    logic [rvPkg::xlen-1:0] opB;

    always_comb begin
        case (fwdA)
            rvPkg::fwdExMem: opA = exMemResult;
            rvPkg::fwdMemWb: opA = memWbResult;
            default:         opA = rData1;
        endcase
        case (fwdB)
            rvPkg::fwdExMem: storeData = exMemResult;
            rvPkg::fwdMemWb: storeData = memWbResult;
            default:         storeData = rData2;
        endcase
    end

    assign opB = aluSrc ? imm : storeData;  // storeData is the forwarded rs2

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:   aluResult = opA + opB;
            rvPkg::aluSub:   aluResult = opA - opB;
            rvPkg::aluAnd:   aluResult = opA & opB;
            rvPkg::aluOr:    aluResult = opA | opB;
            rvPkg::aluXor:   aluResult = opA ^ opB;
            rvPkg::aluSlt:   aluResult = {{(rvPkg::xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            rvPkg::aluPassB: aluResult = opB;
            default:         aluResult = '0;
        endcase
    end

    assign branchTaken  = isBranch && (opA == storeData);
    assign branchTarget = pc + imm;

endmodule

`default_nettype wire

// File: hdl/hazardUnit.sv
//==============================
// Hazard unit
//   load-use stall, branch flush
//   forwarding source selects
//==============================
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [rvPkg::regAddrW-1:0] idRs1,
    input  logic [rvPkg::regAddrW-1:0] idRs2,
    input  logic [rvPkg::regAddrW-1:0] exRs1,
    input  logic [rvPkg::regAddrW-1:0] exRs2,
    input  logic [rvPkg::regAddrW-1:0] exRd,
    input  logic                       exMemRead,
    input  logic                       branchTaken,
    input  logic [rvPkg::regAddrW-1:0] memRd,
    input  logic                       memRegWrite,
    input  logic [rvPkg::regAddrW-1:0] wbRd,
    input  logic                       wbRegWrite,
    output logic                       stallF,
    output logic                       stallD,
    output logic                       bubbleE,
    output logic                       flushD,
    output logic                       flushE,
    output rvPkg::fwdSelE              fwdA,
    output rvPkg::fwdSelE              fwdB
);
    logic loadUse;

    // regWrite already implies a nonzero rd, so no x0 check here
    function automatic rvPkg::fwdSelE pickSource(input logic [rvPkg::regAddrW-1:0] src);
        if (memRegWrite && memRd == src)
            return rvPkg::fwdExMem;   // Youngest value wins
        if (wbRegWrite && wbRd == src)
            return rvPkg::fwdMemWb;
        return rvPkg::fwdNone;
    endfunction

    assign loadUse = exMemRead && (exRd != '0) && (exRd == idRs1 || exRd == idRs2);

    assign stallF  = loadUse;
    assign stallD  = loadUse;
    assign bubbleE = loadUse;
    assign flushD  = branchTaken;
    assign flushE  = branchTaken;

    always_comb begin
        fwdA = pickSource(exRs1);
        fwdB = pickSource(exRs2);
    end

    // A load and a BEQ cannot both sit in EX
    noStallOnFlush: assert final (!(loadUse && branchTaken))
        else $error("load-use stall during a branch flush");

endmodule

`default_nettype wire

// File: hdl/rvCore.sv
//==============================
// Five-stage RV32I pipeline core
//   PC register and fetch redirect
//   stage wiring, memory ports
//   write-back report
//==============================
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
    input  logic                       clk,
    input  logic                       arstN,
    output logic [rvPkg::xlen-1:0]     imemAddr,
    input  logic [rvPkg::instW-1:0]    imemData,
    output logic [rvPkg::xlen-1:0]     dmemAddr,
    output logic [rvPkg::xlen-1:0]     dmemWdata,
    output logic                       dmemWe,
    output logic                       dmemRe,
    input  logic [rvPkg::xlen-1:0]     dmemRdata,
    output logic                       wbValid,
    output logic [rvPkg::regAddrW-1:0] wbRd,
    output logic [rvPkg::xlen-1:0]     wbData
);
    logic [rvPkg::xlen-1:0]     pcF;
    logic [rvPkg::xlen-1:0]     pcD, immD, rData1D, rData2D;
    logic [rvPkg::instW-1:0]    instD;
    logic [rvPkg::regAddrW-1:0] rs1D, rs2D, rdD;
    logic                       validD, regWriteD, memReadD, memWriteD, aluSrcD, isBranchD;
    rvPkg::aluOpE               aluOpD, aluOpE;
    rvPkg::wbSelE               wbSelD, wbSelE, wbSelM, wbSelW;
    logic                       regWriteE, memReadE, memWriteE, aluSrcE, isBranchE;
    logic [rvPkg::regAddrW-1:0] rs1E, rs2E, rdE, rdM, rdW;
    logic [rvPkg::xlen-1:0]     rData1E, rData2E, immE, pcE, aluResultE, storeDataE;
    logic [rvPkg::xlen-1:0]     branchTarget, aluResultM, storeDataM, aluResultW, memDataW;
    logic                       branchTaken, regWriteM, memReadM, memWriteM, regWriteW;
    logic                       stallF, stallD, bubbleE, flushD, flushE;
    rvPkg::fwdSelE              fwdA, fwdB;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pcF <= resetPc;
        else if (branchTaken)
            pcF <= branchTarget;      // Redirect from EX
        else if (!stallF)
            pcF <= pcF + 32'd4;
    end

    assign imemAddr = pcF;

    ifIdReg u_ifId (
        .clk(clk), .arstN(arstN), .stall(stallD), .flush(flushD),
        .pcIn(pcF), .instIn(imemData),
        .pcOut(pcD), .instOut(instD), .validOut(validD)
    );

    decoder u_decoder (
        .inst(instD), .rs1(rs1D), .rs2(rs2D), .rd(rdD),
        .regWrite(regWriteD), .memRead(memReadD), .memWrite(memWriteD),
        .aluSrc(aluSrcD), .aluOp(aluOpD), .wbSel(wbSelD), .isBranch(isBranchD),
        .imm(immD)
    );

    regFile u_regFile (
        .clk(clk), .arstN(arstN), .rs1(rs1D), .rs2(rs2D),
        .we(regWriteW), .wAddr(rdW), .wData(wbData),
        .rData1(rData1D), .rData2(rData2D)
    );

    // Empty decode slots enter EX as bubbles
    idExReg u_idEx (
        .clk(clk), .arstN(arstN), .bubble(bubbleE || !validD), .flush(flushE),
        .regWriteIn(regWriteD), .memReadIn(memReadD), .memWriteIn(memWriteD),
        .aluSrcIn(aluSrcD), .isBranchIn(isBranchD), .aluOpIn(aluOpD), .wbSelIn(wbSelD),
        .rs1In(rs1D), .rs2In(rs2D), .rdIn(rdD),
        .rData1In(rData1D), .rData2In(rData2D), .immIn(immD), .pcIn(pcD),
        .regWriteOut(regWriteE), .memReadOut(memReadE), .memWriteOut(memWriteE),
        .aluSrcOut(aluSrcE), .isBranchOut(isBranchE), .aluOpOut(aluOpE), .wbSelOut(wbSelE),
        .rs1Out(rs1E), .rs2Out(rs2E), .rdOut(rdE),
        .rData1Out(rData1E), .rData2Out(rData2E), .immOut(immE), .pcOut(pcE)
    );

    alu u_alu (
        .aluOp(aluOpE), .aluSrc(aluSrcE), .isBranch(isBranchE), .fwdA(fwdA), .fwdB(fwdB),
        .rData1(rData1E), .rData2(rData2E), .imm(immE), .pc(pcE),
        .exMemResult(aluResultM), .memWbResult(wbData),
        .aluResult(aluResultE), .storeData(storeDataE),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

    hazardUnit u_hazard (
        .idRs1(rs1D), .idRs2(rs2D), .exRs1(rs1E), .exRs2(rs2E), .exRd(rdE),
        .exMemRead(memReadE), .branchTaken(branchTaken),
        .memRd(rdM), .memRegWrite(regWriteM), .wbRd(rdW), .wbRegWrite(regWriteW),
        .stallF(stallF), .stallD(stallD), .bubbleE(bubbleE),
        .flushD(flushD), .flushE(flushE), .fwdA(fwdA), .fwdB(fwdB)
    );

    exMemReg u_exMem (
        .clk(clk), .arstN(arstN),
        .regWriteIn(regWriteE), .memReadIn(memReadE), .memWriteIn(memWriteE),
        .wbSelIn(wbSelE), .rdIn(rdE), .aluResultIn(aluResultE), .storeDataIn(storeDataE),
        .regWriteOut(regWriteM), .memReadOut(memReadM), .memWriteOut(memWriteM),
        .wbSelOut(wbSelM), .rdOut(rdM), .aluResultOut(aluResultM), .storeDataOut(storeDataM)
    );

    assign dmemAddr  = aluResultM;
    assign dmemWdata = storeDataM;
    assign dmemWe    = memWriteM;
    assign dmemRe    = memReadM;

    memWbReg u_memWb (
        .clk(clk), .arstN(arstN),
        .regWriteIn(regWriteM), .wbSelIn(wbSelM), .rdIn(rdM),
        .aluResultIn(aluResultM), .memDataIn(dmemRdata),
        .regWriteOut(regWriteW), .wbSelOut(wbSelW), .rdOut(rdW),
        .aluResultOut(aluResultW), .memDataOut(memDataW)
    );

    // Retirement report, also the register file write
    assign wbData  = (wbSelW == rvPkg::wbMem) ? memDataW : aluResultW;
    assign wbValid = regWriteW;
    assign wbRd    = rdW;

endmodule

`default_nettype wire

// File: tests/rvCoreTb.sv
//==============================
// Testbench for the RV32I core
//   clock, reset, instruction ROM, data RAM
//   directed and random program
//   in-order reference model
//   write-back and store checks
//==============================
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;

    localparam int romWords  = 128;
    localparam int ramWords  = 64;
    localparam int randCount = 24;

    logic                       clk = 1'b0;
    logic                       arstN;
    logic [rvPkg::xlen-1:0]     imemAddr;
    logic [rvPkg::instW-1:0]    imemData;
    logic [rvPkg::xlen-1:0]     dmemAddr;
    logic [rvPkg::xlen-1:0]     dmemWdata;
    logic [rvPkg::xlen-1:0]     dmemRdata;
    logic                       dmemWe;
    logic                       dmemRe;
    logic                       wbValid;
    logic [rvPkg::regAddrW-1:0] wbRd;
    logic [rvPkg::xlen-1:0]     wbData;

    logic [31:0] rom [romWords];
    logic [31:0] ram [ramWords];
    logic [31:0] seed;
    int          progLen     = 0;
    int          limitCycles = 0;

    // Expected retirements and stores, in program order
    logic [4:0]  expRd[$];
    logic [31:0] expData[$];
    logic [31:0] stAddr[$];
    logic [31:0] stData[$];

    rvCore #(.resetPc(32'h0)) i_dut (
        .clk(clk), .arstN(arstN),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWe(dmemWe),
        .dmemRe(dmemRe), .dmemRdata(dmemRdata),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    always #2 clk = ~clk;

    assign imemData  = rom[imemAddr[8:2]];
    assign dmemRdata = dmemRe ? ram[dmemAddr[7:2]] : 'x;  // Combinational read, only when enabled

    always @(posedge clk) begin
        if (dmemWe)
            ram[dmemAddr[7:2]] <= dmemWdata;
    end

    function automatic logic [31:0] fillWord(input int idx);
        return (idx * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::opOp};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    // BEQ only
    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rvPkg::opLui};
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        logic [4:0]  src1;
        logic [4:0]  src2;
        logic [4:0]  dst;
        emit(iType(12'd5, 5'd0, 3'b000, 5'd1, rvPkg::opOpImm));     // x1 = 5
        emit(iType(12'hffd, 5'd0, 3'b000, 5'd2, rvPkg::opOpImm));   // x2 = -3
        emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));               // Both forward paths
        emit(rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        emit(rType(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));
        emit(rType(7'h00, 5'd2, 5'd4, 3'b110, 5'd6));
        emit(rType(7'h00, 5'd3, 5'd6, 3'b100, 5'd7));
        emit(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd8));               // Signed SLT
        emit(uType(20'h12345, 5'd9));
        emit(iType(12'h678, 5'd9, 3'b000, 5'd9, rvPkg::opOpImm));
        emit(sType(12'd8, 5'd9, 5'd0));                             // Store data forwarded
        emit(iType(12'd8, 5'd0, 3'b010, 5'd10, rvPkg::opLoad));
        emit(rType(7'h00, 5'd1, 5'd10, 3'b000, 5'd11));             // Load-use
        emit(iType(12'd12, 5'd0, 3'b010, 5'd12, rvPkg::opLoad));
        emit(iType(12'd1, 5'd12, 3'b000, 5'd13, rvPkg::opOpImm));
        emit(iType(12'd7, 5'd1, 3'b000, 5'd0, rvPkg::opOpImm));     // Write to x0
        emit(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd14));
        emit(sType(12'd16, 5'd11, 5'd0));
        emit(bType(13'd8, 5'd2, 5'd1));                             // Not taken
        emit(iType(12'd21, 5'd0, 3'b000, 5'd15, rvPkg::opOpImm));
        emit(bType(13'd12, 5'd15, 5'd15));                          // Taken, skips two
        emit(iType(12'd99, 5'd0, 3'b000, 5'd16, rvPkg::opOpImm));
        emit(iType(12'd98, 5'd0, 3'b000, 5'd17, rvPkg::opOpImm));
        emit(iType(12'd1, 5'd15, 3'b000, 5'd18, rvPkg::opOpImm));
        emit(iType(12'd16, 5'd0, 3'b010, 5'd19, rvPkg::opLoad));
        emit(sType(12'd20, 5'd19, 5'd0));                           // Load-use on store data
        // Random ALU tail over x0..x15 for dense dependencies
        for (int i = 0; i < randCount; i++) begin
            r    = $random(seed);
            src1 = {1'b0, r[7:4]};
            src2 = {1'b0, r[11:8]};
            dst  = {1'b0, r[15:12]};
            case (r[2:0])
                3'd0: emit(rType(7'h00, src2, src1, 3'b000, dst));
                3'd1: emit(rType(7'h20, src2, src1, 3'b000, dst));
                3'd2: emit(rType(7'h00, src2, src1, 3'b111, dst));
                3'd3: emit(rType(7'h00, src2, src1, 3'b110, dst));
                3'd4: emit(rType(7'h00, src2, src1, 3'b100, dst));
                3'd5: emit(rType(7'h00, src2, src1, 3'b010, dst));
                3'd6: emit(iType(r[27:16], src1, 3'b000, dst, rvPkg::opOpImm));
                default: emit(uType(r[31:12], dst));
            endcase
        end
        emit(bType(13'd0, 5'd0, 5'd0));  // Halt, branch to self
    endtask

    // ISA-level model, one instruction per step
    task automatic runModel(output int executed);
        logic [31:0] x [32];
        logic [31:0] mem [ramWords];
        logic [31:0] pc, nextPc, inst, a, b, res, addr, immI, immS, immB;
        logic [4:0]  rd;
        logic        writes;
        logic        halted;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        for (int i = 0; i < ramWords; i++)
            mem[i] = fillWord(i);
        pc       = '0;
        executed = 0;
        halted   = 1'b0;
        while (!halted && executed < 1000) begin
            inst   = rom[pc[8:2]];
            a      = x[inst[19:15]];
            b      = x[inst[24:20]];
            rd     = inst[11:7];
            immI   = {{20{inst[31]}}, inst[31:20]};
            immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immB   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            nextPc = pc + 32'd4;
            writes = 1'b0;
            res    = '0;
            executed++;
            case (inst[6:0])
                rvPkg::opOp: begin
                    writes = 1'b1;
                    case ({inst[30], inst[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0111: res = a & b;
                        4'b0110: res = a | b;
                        4'b0100: res = a ^ b;
                        4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                rvPkg::opOpImm: begin
                    res    = a + immI;
                    writes = 1'b1;
                end
                rvPkg::opLui: begin
                    res    = {inst[31:12], 12'h000};
                    writes = 1'b1;
                end
                rvPkg::opLoad: begin
                    addr   = a + immI;
                    res    = mem[addr[7:2]];
                    writes = 1'b1;
                end
                rvPkg::opStore: begin
                    addr = a + immS;
                    mem[addr[7:2]] = b;
                    stAddr.push_back(addr);
                    stData.push_back(b);
                end
                rvPkg::opBranch: begin
                    if (a == b)
                        nextPc = pc + immB;
                    halted = (nextPc == pc);
                end
                default: ;
            endcase
            if (writes && rd != 5'd0) begin
                x[rd] = res;
                expRd.push_back(rd);
                expData.push_back(res);
            end
            pc = nextPc;
        end
    endtask

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkResetState();
        assert (!wbValid)
            else reportFailure($sformatf("[FAIL] %0t wbValid: got %b expected 0", $time, wbValid));
        assert (!dmemWe)
            else reportFailure($sformatf("[FAIL] %0t dmemWe: got %b expected 0", $time, dmemWe));
        assert (!dmemRe)
            else reportFailure($sformatf("[FAIL] %0t dmemRe: got %b expected 0", $time, dmemRe));
        assert (imemAddr == 32'h0)
            else reportFailure($sformatf("[FAIL] %0t imemAddr: got %h expected %h",
                                         $time, imemAddr, 32'h0));
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (wbValid) begin
            assert (wbRd != 5'd0)
                else reportFailure($sformatf("[FAIL] %0t wbRd: got %0d expected nonzero",
                                             $time, wbRd));
            assert (expRd.size() > 0)
                else reportFailure($sformatf("Register write to x%0d at %0t after the last one",
                                             wbRd, $time));
            assert (wbRd == expRd[0])
                else reportFailure($sformatf("[FAIL] %0t wbRd: got %0d expected %0d",
                                             $time, wbRd, expRd[0]));
            assert (wbData == expData[0])
                else reportFailure($sformatf("[FAIL] %0t wbData: got %h expected %h",
                                             $time, wbData, expData[0]));
            void'(expRd.pop_front());
            void'(expData.pop_front());
        end
        if (dmemWe) begin
            assert (stAddr.size() > 0)
                else reportFailure($sformatf("Memory write at %0t after the last store", $time));
            assert (dmemAddr == stAddr[0])
                else reportFailure($sformatf("[FAIL] %0t dmemAddr: got %h expected %h",
                                             $time, dmemAddr, stAddr[0]));
            assert (dmemWdata == stData[0])
                else reportFailure($sformatf("[FAIL] %0t dmemWdata: got %h expected %h",
                                             $time, dmemWdata, stData[0]));
            void'(stAddr.pop_front());
            void'(stData.pop_front());
        end
    end

    initial begin
        int executed;
        arstN = 1'b0;
        seed  = 32'h0514bc44;
        for (int i = 0; i < romWords; i++)
            rom[i] = {i[24:0], 7'h7f};  // Unused opcode, decodes as a bubble
        for (int i = 0; i < ramWords; i++)
            ram[i] = fillWord(i);
        buildProgram();
        runModel(executed);
        limitCycles = 2 * executed * 3;
        repeat (4) begin
            @(negedge clk);
            checkResetState();
        end
        arstN = 1'b1;
        checkResetState();  // PC not advanced yet
        while (expRd.size() > 0 || stAddr.size() > 0)
            @(negedge clk);
        repeat (8) @(negedge clk);  // Catch stray writes
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        reportFailure($sformatf("Timeout after %0d cycles with %0d writes and %0d stores missing",
                                limitCycles, expRd.size(), stAddr.size()));
    end

endmodule

`default_nettype wire

// File: build.f
common/rvPkg.sv
pipeline/pipeRegs.sv
hdl/decoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/hazardUnit.sv
hdl/rvCore.sv
tests/rvCoreTb.sv
